//--- logic/testchip_params.svh
`ifndef TESTCHIP_PARAMS_SVH
`define TESTCHIP_PARAMS_SVH

// Macro array geometry
`define TC_ADDR_W      4
`define TC_DEPTH       16

// Narrower macros use the low bits of this widest word
`define TC_DATA_W      64

// Macro select and number of populated macros
`define TC_SEL_W       3
`define TC_NUM_MACROS  3

// Command packet width, which is also the serial frame length in bits
`define TC_PKT_W       78
`define TC_SER_CNT_W   7

`endif

//--- logic/testchip_pkg.sv
`include "testchip_params.svh"

package testchip_pkg;

  // Host command with sel as the top field and din[0] as the first serial bit
  typedef struct packed {
    logic [`TC_SEL_W-1:0]  sel;
    logic                  csb;      // Main port select, active low
    logic                  web;      // Write enable, active low
    logic [`TC_ADDR_W-1:0] addr;
    logic                  ro_csb;   // Read-only port select, active low
    logic [`TC_ADDR_W-1:0] ro_addr;
    logic [`TC_DATA_W-1:0] din;
  } sram_packet_t;

  // Pins of one macro as driven by the router
  typedef struct packed {
    logic                  csb;
    logic                  web;
    logic [`TC_ADDR_W-1:0] addr;
    logic                  ro_csb;
    logic [`TC_ADDR_W-1:0] ro_addr;
    logic [`TC_DATA_W-1:0] din;
  } sram_port_t;

  // Word returned to the host
  typedef struct packed {
    logic [`TC_SEL_W-1:0]  sel;
    logic [`TC_DATA_W-1:0] data;
  } read_result_t;

  // Macro word types
  typedef logic [31:0]            word32_t;
  typedef logic [`TC_DATA_W-1:0]  word64_t;

endpackage

//--- logic/packet_loader.sv
`timescale 1ns/1ps
`include "testchip_params.svh"

module packet_loader (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       req,
  input  logic                       serial_mode,
  input  testchip_pkg::sram_packet_t pkt,
  input  logic                       ser_bit,
  input  logic                       done,
  output logic                       ack,
  output logic                       cmd_valid,
  output testchip_pkg::sram_packet_t cmd
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SHIFT,
    ST_ISSUE,
    ST_WAIT,
    ST_HOLD
  } state_t;

  state_t                    state;
  logic [`TC_SER_CNT_W-1:0]  bit_cnt;
  testchip_pkg::sram_packet_t pkt_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= ST_IDLE;
      bit_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (req) begin
            if (serial_mode) begin
              state   <= ST_SHIFT;
              bit_cnt <= `TC_SER_CNT_W'(1); // First bit taken on this edge
            end else begin
              state <= ST_ISSUE;
            end
          end
        end
        ST_SHIFT: begin
          bit_cnt <= bit_cnt + `TC_SER_CNT_W'(1);
          if (bit_cnt == `TC_SER_CNT_W'(`TC_PKT_W - 1)) begin
            state <= ST_ISSUE; // Last bit lands on this edge
          end
        end
        ST_ISSUE: state <= ST_WAIT;
        ST_WAIT: begin
          if (done) begin
            state <= ST_HOLD;
          end
        end
        ST_HOLD: begin
          if (!req) begin
            state <= ST_IDLE; // Back to idle only once req drops
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Packet register shifted LSB first in serial mode
  always_ff @(posedge clk) begin
    if ((state == ST_IDLE && req && serial_mode) || state == ST_SHIFT) begin
      pkt_q <= testchip_pkg::sram_packet_t'({ser_bit, pkt_q[`TC_PKT_W-1:1]});
    end else if (state == ST_IDLE && req) begin
      pkt_q <= pkt;
    end
  end

  assign cmd       = pkt_q;
  assign cmd_valid = (state == ST_ISSUE);
  assign ack       = (state == ST_HOLD);

endmodule

//--- logic/sram_router.sv
`timescale 1ns/1ps
`include "testchip_params.svh"

module sram_router (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       cmd_valid,
  input  testchip_pkg::sram_packet_t cmd,
  output testchip_pkg::sram_port_t   port0,
  output testchip_pkg::sram_port_t   port1,
  output testchip_pkg::sram_port_t   port2,
  input  testchip_pkg::word32_t      rdata0,
  input  testchip_pkg::word32_t      ro_rdata0,
  input  testchip_pkg::word32_t      rdata1,
  input  testchip_pkg::word64_t      rdata2,
  output logic                       done,
  output testchip_pkg::read_result_t result
);

  localparam testchip_pkg::sram_port_t IDLE_PORT = '{
    csb: 1'b1, web: 1'b1, addr: '0, ro_csb: 1'b1, ro_addr: '0, din: '0
  };

  testchip_pkg::sram_port_t    cmd_port;
  logic [`TC_NUM_MACROS-1:0]   sel_hot;
  logic                        stage1;
  logic                        stage2;
  logic [`TC_SEL_W-1:0]        op_sel;
  logic                        op_web;
  logic                        op_ro_csb;
  logic [`TC_DATA_W-1:0]       rd_word;

  assign cmd_port = '{
    csb: cmd.csb, web: cmd.web, addr: cmd.addr,
    ro_csb: cmd.ro_csb, ro_addr: cmd.ro_addr, din: cmd.din
  };

  // Out-of-range selects shift out and decode to no macro
  assign sel_hot = cmd_valid ? (`TC_NUM_MACROS'(1) << cmd.sel) : '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      port0  <= IDLE_PORT;
      port1  <= IDLE_PORT;
      port2  <= IDLE_PORT;
      stage1 <= 1'b0;
      stage2 <= 1'b0;
      done   <= 1'b0;
      result <= '0;
    end else begin
      port0  <= sel_hot[0] ? cmd_port : IDLE_PORT;
      port1  <= sel_hot[1] ? cmd_port : IDLE_PORT;
      port2  <= sel_hot[2] ? cmd_port : IDLE_PORT;
      stage1 <= cmd_valid;  // Port driven to macro
      stage2 <= stage1;     // Macro access done and read data valid
      done   <= stage2;
      if (stage2 && op_web) begin
        result <= '{sel: op_sel, data: rd_word};
      end
    end
  end

  // Fields needed at capture time
  always_ff @(posedge clk) begin
    if (cmd_valid) begin
      op_sel    <= cmd.sel;
      op_web    <= cmd.web;
      op_ro_csb <= cmd.ro_csb;
    end
  end

  always_comb begin
    case (op_sel)
      `TC_SEL_W'(0): rd_word = op_ro_csb ? `TC_DATA_W'(rdata0) : `TC_DATA_W'(ro_rdata0);
      `TC_SEL_W'(1): rd_word = op_ro_csb ? `TC_DATA_W'(rdata1) : '0;
      `TC_SEL_W'(2): rd_word = op_ro_csb ? rdata2 : '0; // No read-only port on sram2
      default:       rd_word = '0;
    endcase
  end

endmodule

//--- logic/sram_macro.sv
`timescale 1ns/1ps
`include "testchip_params.svh"

module sram_macro #(
  parameter type word_t = testchip_pkg::word32_t,
  parameter bit  HAS_RO = 1'b0
) (
  input  logic                     clk,
  input  testchip_pkg::sram_port_t port,
  output word_t                    rdata,
  output word_t                    ro_rdata
);

  localparam int WORD_W = $bits(word_t);

  word_t mem [`TC_DEPTH];

  // Main port writes on web low and reads otherwise
  always_ff @(posedge clk) begin
    if (!port.csb) begin
      if (!port.web) begin
        mem[port.addr] <= port.din[WORD_W-1:0]; // Upper din bits dropped on narrow macros
      end else begin
        rdata <= mem[port.addr];
      end
    end
  end

  generate
    if (HAS_RO) begin : g_ro
      always_ff @(posedge clk) begin
        if (!port.ro_csb) begin
          ro_rdata <= mem[port.ro_addr];
        end
      end
    end else begin : g_no_ro
      assign ro_rdata = '0;
    end
  endgenerate

endmodule

//--- logic/testchip_top.sv
`timescale 1ns/1ps

module testchip_top (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       req,
  input  logic                       serial_mode,
  input  testchip_pkg::sram_packet_t pkt,
  input  logic                       ser_bit,
  output logic                       ack,
  output testchip_pkg::read_result_t result
);

  logic                       cmd_valid;
  logic                       done;
  testchip_pkg::sram_packet_t cmd;
  testchip_pkg::sram_port_t   port0;
  testchip_pkg::sram_port_t   port1;
  testchip_pkg::sram_port_t   port2;
  testchip_pkg::word32_t      rdata0;
  testchip_pkg::word32_t      ro_rdata0;
  testchip_pkg::word32_t      rdata1;
  testchip_pkg::word64_t      rdata2;

  packet_loader u_loader (
    .clk         (clk),
    .reset       (reset),
    .req         (req),
    .serial_mode (serial_mode),
    .pkt         (pkt),
    .ser_bit     (ser_bit),
    .done        (done),
    .ack         (ack),
    .cmd_valid   (cmd_valid),
    .cmd         (cmd)
  );

  sram_router u_router (
    .clk       (clk),
    .reset     (reset),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .port0     (port0),
    .port1     (port1),
    .port2     (port2),
    .rdata0    (rdata0),
    .ro_rdata0 (ro_rdata0),
    .rdata1    (rdata1),
    .rdata2    (rdata2),
    .done      (done),
    .result    (result)
  );

  // 32 bit macro with read/write and read-only ports
  sram_macro #(.word_t(testchip_pkg::word32_t), .HAS_RO(1'b1)) sram0 (
    .clk      (clk),
    .port     (port0),
    .rdata    (rdata0),
    .ro_rdata (ro_rdata0)
  );

  sram_macro #(.word_t(testchip_pkg::word32_t), .HAS_RO(1'b0)) sram1 (
    .clk      (clk),
    .port     (port1),
    .rdata    (rdata1),
    .ro_rdata ()
  );

  sram_macro #(.word_t(testchip_pkg::word64_t), .HAS_RO(1'b0)) sram2 (
    .clk      (clk),
    .port     (port2),
    .rdata    (rdata2),
    .ro_rdata ()
  );

endmodule

//--- tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
  parameter int HALF_PERIOD = 50
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #(HALF_PERIOD) clk = ~clk;
    end
  end

endmodule

//--- tb/testchip_sva.sv
`timescale 1ns/1ps

module testchip_sva (
  input logic clk,
  input logic reset,
  input logic req,
  input logic ack
);

  ack_reset_low: assert property (@(posedge clk) reset |=> !ack)
    else $error("ack high after a reset cycle");

  // Ack holds until the host drops req
  ack_held: assert property (@(posedge clk) disable iff (reset) (ack && req) |=> ack)
    else $error("ack fell while req was high");

  ack_needs_req: assert property (@(posedge clk) disable iff (reset) $rose(ack) |-> req)
    else $error("ack rose without req");

endmodule

bind packet_loader testchip_sva u_sva (
  .clk   (clk),
  .reset (reset),
  .req   (req),
  .ack   (ack)
);

//--- tb/testchip_tb.sv
`timescale 1ns/1ps
`include "testchip_params.svh"

module testchip_tb;

  logic                       clk;
  logic                       reset;
  logic                       req;
  logic                       serial_mode;
  logic                       ser_bit;
  logic                       ack;
  testchip_pkg::sram_packet_t pkt;
  testchip_pkg::read_result_t result;
  testchip_pkg::read_result_t expected;

  logic [31:0] ref0 [`TC_DEPTH];
  logic [31:0] ref1 [`TC_DEPTH];
  logic [63:0] ref2 [`TC_DEPTH];
  logic [15:0] lfsr;
  logic        ack_q;
  bit          abort;
  int          cmp_checks;
  int          cmp_errors;
  int          proto_errors;
  int          err_mark;
  int          chk_mark;
  int          test_count;
  int          tests_failed;

  tb_clock clock_gen (.clk(clk));

  testchip_top uut (
    .clk         (clk),
    .reset       (reset),
    .req         (req),
    .serial_mode (serial_mode),
    .pkt         (pkt),
    .ser_bit     (ser_bit),
    .ack         (ack),
    .result      (result)
  );

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr); // One step per bit
      v[i] = lfsr[0];
    end
    return v;
  endfunction

  function automatic testchip_pkg::sram_packet_t make_pkt(
    input logic [2:0] sel, input logic web, input logic [3:0] addr,
    input logic ro_csb, input logic [3:0] ro_addr, input logic [63:0] din);
    return '{sel: sel, csb: 1'b0, web: web, addr: addr,
             ro_csb: ro_csb, ro_addr: ro_addr, din: din};
  endfunction

  // Memory model and result rule giving the result expected after p
  function automatic testchip_pkg::read_result_t model_access(
    input testchip_pkg::sram_packet_t p, input testchip_pkg::read_result_t prev);
    logic [63:0] word;
    word = '0;
    if (!p.web) begin
      if (!p.csb) begin
        case (p.sel)
          3'd0: ref0[p.addr] = p.din[31:0];
          3'd1: ref1[p.addr] = p.din[31:0];
          3'd2: ref2[p.addr] = p.din;
          default: ;
        endcase
      end
      return prev; // Writes keep the last read
    end
    if (!p.ro_csb) begin
      if (p.sel == 3'd0) word = {32'd0, ref0[p.ro_addr]};
    end else begin
      case (p.sel)
        3'd0: word = {32'd0, ref0[p.addr]};
        3'd1: word = {32'd0, ref1[p.addr]};
        3'd2: word = ref2[p.addr];
        default: word = '0;
      endcase
    end
    return '{sel: p.sel, data: word};
  endfunction

  task automatic wait_ack(input logic level, output bit ok);
    ok = 1'b0;
    for (int n = 0; n < 200 && !ok; n++) begin
      @(negedge clk);
      ok = (ack === level);
    end
  endtask

  // One four-phase transfer with hold extra cycles on each side of ack
  task automatic run_op(input testchip_pkg::sram_packet_t p, input logic ser, input int hold);
    bit ok;
    if (abort) return;
    assert (ack === 1'b0) else begin
      proto_errors++;
      $display("ack was high before req was raised");
    end
    expected = model_access(p, expected);
    @(posedge clk);
    pkt         <= ser ? ~p : p; // Serial packets come from ser_bit only
    serial_mode <= ser;
    ser_bit     <= p[0];
    req         <= 1'b1;
    if (ser) begin
      for (int i = 1; i < `TC_PKT_W; i++) begin
        @(posedge clk);
        ser_bit <= p[i]; // LSB first
      end
    end
    wait_ack(1'b1, ok);
    if (!ok) begin
      $display("Timeout waiting for ack to rise");
      proto_errors++;
      abort = 1'b1;
      return;
    end
    repeat (hold) begin
      @(negedge clk);
      assert (ack === 1'b1) else begin
        proto_errors++;
        $display("ack dropped while req was still high");
      end
    end
    @(posedge clk);
    req <= 1'b0;
    wait_ack(1'b0, ok);
    if (!ok) begin
      $display("Timeout waiting for ack to fall after req dropped");
      proto_errors++;
      abort = 1'b1;
      return;
    end
    repeat (hold) begin
      @(negedge clk);
      assert (ack === 1'b0) else begin
        proto_errors++;
        $display("ack rose again with req low, stray operation");
      end
    end
  endtask

  task automatic finish_test(input string name);
    int errs;
    errs = cmp_errors + proto_errors - err_mark;
    test_count++;
    if (errs != 0) tests_failed++;
    $display("Test %-20s %0d checks, %0d errors", name, cmp_checks - chk_mark, errs);
    err_mark = cmp_errors + proto_errors;
    chk_mark = cmp_checks;
  endtask

  // Compare once per rising ack
  always @(negedge clk) begin
    if (!reset && ack === 1'b1 && ack_q !== 1'b1) begin
      cmp_checks++;
      assert (result === expected) else begin
        cmp_errors++;
        $display("FAIL result.data = %h (expected %h), result.sel = %h (expected %h)",
                 result.data, expected.data, result.sel, expected.sel);
      end
    end
    ack_q = ack;
  end

  initial begin
    logic [2:0] sel;
    logic [3:0] a;
    logic [3:0] b;
    reset        = 1'b1;
    req          = 1'b0;
    serial_mode  = 1'b0;
    ser_bit      = 1'b0;
    pkt          = '0;
    expected     = '0;
    lfsr         = 16'd58;
    abort        = 1'b0;
    cmp_checks   = 0;
    cmp_errors   = 0;
    proto_errors = 0;
    err_mark     = 0;
    chk_mark     = 0;
    test_count   = 0;
    tests_failed = 0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);

    for (int s = 0; s < 3; s++) begin // Fill every word, then read all back
      for (int i = 0; i < `TC_DEPTH; i++) begin
        run_op(make_pkt(3'(s), 1'b0, 4'(i), 1'b1, 4'd0, rand_bits(64)), 1'b0, 0);
      end
      for (int i = 0; i < `TC_DEPTH; i++) begin
        run_op(make_pkt(3'(s), 1'b1, 4'(i), 1'b1, 4'd0, 64'd0), 1'b0, 0);
      end
    end
    finish_test("parallel_rw");

    for (int i = 0; i < 6; i++) begin
      sel = 3'(rand_bits(2) % 64'd3);
      a   = 4'(rand_bits(4));
      run_op(make_pkt(sel, 1'b0, a, 1'b1, 4'd0, rand_bits(64)), 1'b1, 0);
      run_op(make_pkt(sel, 1'b1, a, 1'b1, 4'd0, 64'd0), 1'b1, 0);
      run_op(make_pkt(sel, 1'b1, a, 1'b1, 4'd0, 64'd0), 1'b0, 0);
    end
    finish_test("serial_load");

    for (int i = 0; i < 6; i++) begin
      a = 4'(rand_bits(4));
      b = 4'(rand_bits(4));
      run_op(make_pkt(3'd0, 1'b0, a, 1'b1, 4'd0, rand_bits(64)), 1'b0, 0);
      run_op(make_pkt(3'd0, 1'b1, b, 1'b0, a, 64'd0), 1'b0, 0);
    end
    finish_test("read_only_port");

    for (int s = 3; s < 8; s++) begin
      a = 4'(rand_bits(4));
      run_op(make_pkt(3'(s), 1'b0, a, 1'b1, 4'd0, rand_bits(64)), 1'b0, 0);
      run_op(make_pkt(3'(s), 1'b1, a, 1'b1, 4'd0, 64'd0), 1'b0, 0);
      for (int m = 0; m < 3; m++) begin
        run_op(make_pkt(3'(m), 1'b1, a, 1'b1, 4'd0, 64'd0), 1'b0, 0);
      end
    end
    finish_test("invalid_select");

    for (int i = 0; i < 6; i++) begin
      sel = 3'(rand_bits(2) % 64'd3);
      run_op(make_pkt(sel, 1'b1, 4'(rand_bits(4)), 1'b1, 4'd0, 64'd0), 1'b0, 0);
      sel = 3'(rand_bits(2) % 64'd3);
      run_op(make_pkt(sel, 1'b0, 4'(rand_bits(4)), 1'b1, 4'd0, rand_bits(64)), 1'b0, 0);
    end
    finish_test("write_keeps_result");

    run_op(make_pkt(3'd2, 1'b1, 4'(rand_bits(4)), 1'b1, 4'd0, 64'd0), 1'b0, 4);
    run_op(make_pkt(3'd1, 1'b1, 4'(rand_bits(4)), 1'b1, 4'd0, 64'd0), 1'b1, 4);
    finish_test("handshake");

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             test_count, tests_failed, cmp_checks, cmp_errors + proto_errors);
    if (cmp_errors + proto_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+logic
logic/testchip_pkg.sv
logic/packet_loader.sv
logic/sram_router.sv
logic/sram_macro.sv
logic/testchip_top.sv
tb/tb_clock.sv
tb/testchip_sva.sv
tb/testchip_tb.sv

//--- Makefile
TOP = testchip_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	! grep -q "TESTS FAILED" sim.log

clean:
	rm -rf obj_dir sim.log
